/* hw/rat_config_pkg.sv */
// table dimensions for the register alias table
// 16 architectural registers map onto 32 physical tags
// PHYS_REGS must be at least ARCH_REGS so the reset identity mapping fits
// register ZERO_REG is never renamed and always reads tag 0, ready

`default_nettype none

package rat_config_pkg;

    // ========================================================================
    // sizes
    // ========================================================================

    // architectural registers seen by the rename stage
    localparam int ARCH_REGS = 16;
    // physical tags in the register file
    localparam int PHYS_REGS = 32;
    // result buses that can mark a tag ready in one cycle
    localparam int WB_PORTS = 2;

    // derived field widths
    localparam int ARCH_IDX_W = $clog2(ARCH_REGS);
    localparam int PHYS_TAG_W = $clog2(PHYS_REGS);

    // ========================================================================
    // field types
    // ========================================================================

    // index of an architectural register
    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
    // physical register tag
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;
    // one valid bit per writeback port
    typedef logic [WB_PORTS-1:0] wb_vec_t;

    // hardwired zero register, rename requests to it are dropped
    localparam arch_idx_t ZERO_REG = arch_idx_t'(0);

endpackage

`default_nettype wire

/* hw/rat_snapshot_pkg.sv */
// flat vector layouts for the whole-table snapshot and the writeback tags
// entry i of a tag vector sits at bits [i*SNAP_SLICE_W +: SNAP_SLICE_W]
// writeback port p uses the same slicing inside wb_tags_t

`default_nettype none

package rat_snapshot_pkg;

    // width of one tag slice inside a packed vector
    localparam int SNAP_SLICE_W = rat_config_pkg::PHYS_TAG_W;

    // all table tags side by side
    localparam int SNAP_TAGS_W = rat_config_pkg::ARCH_REGS * SNAP_SLICE_W;

    // all writeback tags side by side
    localparam int WB_TAGS_W = rat_config_pkg::WB_PORTS * SNAP_SLICE_W;

    // one bit per architectural register
    // used for ready bits and for writeback match masks
    typedef logic [rat_config_pkg::ARCH_REGS-1:0] arch_vec_t;

    // tag of every entry, entry 0 in the low slice
    typedef logic [SNAP_TAGS_W-1:0] snap_tags_t;

    // tags of every writeback port, port 0 in the low slice
    typedef logic [WB_TAGS_W-1:0] wb_tags_t;

endpackage

`default_nettype wire

/* hw/rat_wb_match.sv */
// writeback tag match for every table entry and every restore-snapshot entry
// purely combinational, a port only counts while its valid bit is high
// matches from all ports are ORed into one mask per source

`timescale 1ns/1ps
`default_nettype none

module rat_wb_match (
    input  var rat_config_pkg::wb_vec_t      wb_valid_i,
    input  var rat_snapshot_pkg::wb_tags_t   wb_tag_i,
    input  var rat_snapshot_pkg::snap_tags_t cur_tags_i,
    input  var rat_snapshot_pkg::snap_tags_t restore_tags_i,
    output var rat_snapshot_pkg::arch_vec_t  table_hit_o,
    output var rat_snapshot_pkg::arch_vec_t  snap_hit_o
);

    import rat_config_pkg::*;
    import rat_snapshot_pkg::*;

    // true if any valid writeback port carries this tag
    function automatic logic tag_hit(
        input phys_tag_t tag,
        input wb_vec_t   valid,
        input wb_tags_t  wb_tags
    );
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (valid[p] && (wb_tags[p*SNAP_SLICE_W +: SNAP_SLICE_W] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ========================================================================
    // per-entry compare
    // ========================================================================

    for (genvar i = 0; i < ARCH_REGS; i++) begin : g_entry
        // current table entry, used for forwarding and for the next ready bit
        assign table_hit_o[i] = tag_hit(cur_tags_i[i*SNAP_SLICE_W +: SNAP_SLICE_W],
                                        wb_valid_i, wb_tag_i);

        // snapshot entry being restored, so a result landing in the
        // restore cycle is not lost
        assign snap_hit_o[i] = tag_hit(restore_tags_i[i*SNAP_SLICE_W +: SNAP_SLICE_W],
                                       wb_valid_i, wb_tag_i);
    end

endmodule

`default_nettype wire

/* hw/rat_table.sv */
// mapping state of the alias table, one tag and one ready bit per entry
// synchronous active-high reset loads the identity mapping, all ready
// restore has priority over rename in the same cycle
// snapshot outputs show the next state as if no restore were applied

`timescale 1ns/1ps
`default_nettype none

module rat_table (
    input  var logic                         clock,
    input  var logic                         reset,
    input  var logic                         ren_valid_i,
    input  var rat_config_pkg::arch_idx_t    ren_arch_i,
    input  var rat_config_pkg::phys_tag_t    ren_tag_i,
    input  var rat_snapshot_pkg::arch_vec_t  table_hit_i,
    input  var rat_snapshot_pkg::arch_vec_t  snap_hit_i,
    input  var logic                         restore_valid_i,
    input  var rat_snapshot_pkg::snap_tags_t restore_tags_i,
    input  var rat_snapshot_pkg::arch_vec_t  restore_ready_i,
    output var rat_snapshot_pkg::snap_tags_t cur_tags_o,
    output var rat_snapshot_pkg::arch_vec_t  cur_ready_o,
    output var rat_snapshot_pkg::snap_tags_t snap_tags_o,
    output var rat_snapshot_pkg::arch_vec_t  snap_ready_o
);

    import rat_config_pkg::*;
    import rat_snapshot_pkg::*;

    // registered table
    snap_tags_t tags_q;
    arch_vec_t  ready_q;

    // next state for a normal cycle (rename plus writebacks)
    snap_tags_t norm_tags;
    arch_vec_t  norm_ready;

    // ready bits after a restore merge
    arch_vec_t  rst_ready;

    // full next state
    snap_tags_t tags_d;
    arch_vec_t  ready_d;

    // rename request that actually changes the table
    logic       ren_active;

    assign ren_active = ren_valid_i && (ren_arch_i != ZERO_REG);

    // ========================================================================
    // normal update
    // ========================================================================

    always_comb begin
        norm_tags = tags_q;
        // every entry holding a written tag becomes ready
        norm_ready = ready_q | table_hit_i;
        // the renamed entry gets its new tag and waits for its producer,
        // this also overrides a writeback hit on the old tag
        if (ren_active) begin
            norm_tags[ren_arch_i*SNAP_SLICE_W +: SNAP_SLICE_W] = ren_tag_i;
            norm_ready[ren_arch_i] = 1'b0;
        end
    end

    // ========================================================================
    // restore merge
    // ========================================================================

    always_comb begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            // ready if the snapshot says so
            // or the entry keeps a tag that is already ready here
            // or the snapshot tag is written back in this very cycle
            rst_ready[i] = restore_ready_i[i]
                         | ((restore_tags_i[i*SNAP_SLICE_W +: SNAP_SLICE_W]
                             == tags_q[i*SNAP_SLICE_W +: SNAP_SLICE_W]) && ready_q[i])
                         | snap_hit_i[i];
        end
    end

    // restore wins over the rename slot
    assign tags_d  = restore_valid_i ? restore_tags_i : norm_tags;
    assign ready_d = restore_valid_i ? rst_ready : norm_ready;

    // ========================================================================
    // state registers
    // ========================================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity: entry i holds tag i
            for (int i = 0; i < ARCH_REGS; i++) begin
                tags_q[i*SNAP_SLICE_W +: SNAP_SLICE_W] <= phys_tag_t'(i);
            end
            ready_q <= '1;
        end else begin
            tags_q  <= tags_d;
            ready_q <= ready_d;
        end
    end

    // current table to lookup and match logic
    assign cur_tags_o  = tags_q;
    assign cur_ready_o = ready_q;

    // checkpoint view, what the table holds after this cycle's rename
    // and writebacks, for the consumer to save at a branch
    assign snap_tags_o  = norm_tags;
    assign snap_ready_o = norm_ready;

endmodule

`default_nettype wire

/* hw/rat_lookup.sv */
// combinational read side of the alias table
// source ready bits forward same-cycle writebacks through the table_hit mask
// old-tag read follows the restore snapshot while a restore is active
// a rename of ZERO_REG still reports its stored tag

`timescale 1ns/1ps
`default_nettype none

module rat_lookup (
    input  var rat_config_pkg::arch_idx_t    rs1_arch_i,
    input  var rat_config_pkg::arch_idx_t    rs2_arch_i,
    input  var rat_config_pkg::arch_idx_t    ren_arch_i,
    input  var rat_snapshot_pkg::snap_tags_t cur_tags_i,
    input  var rat_snapshot_pkg::arch_vec_t  cur_ready_i,
    input  var rat_snapshot_pkg::arch_vec_t  table_hit_i,
    input  var logic                         restore_valid_i,
    input  var rat_snapshot_pkg::snap_tags_t restore_tags_i,
    output var rat_config_pkg::phys_tag_t    rs1_tag_o,
    output var rat_config_pkg::phys_tag_t    rs2_tag_o,
    output var logic                         rs1_ready_o,
    output var logic                         rs2_ready_o,
    output var rat_config_pkg::phys_tag_t    ren_old_tag_o
);

    import rat_config_pkg::*;
    import rat_snapshot_pkg::*;

    // pick one entry's tag out of a flat tag vector
    function automatic phys_tag_t tag_at(
        input snap_tags_t tags,
        input arch_idx_t  idx
    );
        return tags[int'(idx)*SNAP_SLICE_W +: SNAP_SLICE_W];
    endfunction

    // ========================================================================
    // source operands
    // ========================================================================

    assign rs1_tag_o = tag_at(cur_tags_i, rs1_arch_i);
    assign rs2_tag_o = tag_at(cur_tags_i, rs2_arch_i);

    // stored ready or a writeback hitting that entry right now
    assign rs1_ready_o = cur_ready_i[rs1_arch_i] | table_hit_i[rs1_arch_i];
    assign rs2_ready_o = cur_ready_i[rs2_arch_i] | table_hit_i[rs2_arch_i];

    // ========================================================================
    // rename destination
    // ========================================================================

    // during a restore the table is about to become the snapshot,
    // so the tag being freed is the snapshot's one
    assign ren_old_tag_o = restore_valid_i ? tag_at(restore_tags_i, ren_arch_i)
                                           : tag_at(cur_tags_i, ren_arch_i);

endmodule

`default_nettype wire

/* hw/rat_top.sv */
// register alias table for the rename stage, one rename slot per cycle
// two source lookups and two writeback ports, no handshakes
// lookups, old tag and snapshot respond in the same cycle
// rename, writeback and restore show up in the table after the next edge

`timescale 1ns/1ps
`default_nettype none

module rat_top (
    input  var logic                         clock,
    input  var logic                         reset,
    // source lookups
    input  var rat_config_pkg::arch_idx_t    rs1_arch_i,
    input  var rat_config_pkg::arch_idx_t    rs2_arch_i,
    output var rat_config_pkg::phys_tag_t    rs1_tag_o,
    output var rat_config_pkg::phys_tag_t    rs2_tag_o,
    output var logic                         rs1_ready_o,
    output var logic                         rs2_ready_o,
    // rename slot
    input  var logic                         ren_valid_i,
    input  var rat_config_pkg::arch_idx_t    ren_arch_i,
    input  var rat_config_pkg::phys_tag_t    ren_tag_i,
    output var rat_config_pkg::phys_tag_t    ren_old_tag_o,
    // writebacks
    input  var rat_config_pkg::wb_vec_t      wb_valid_i,
    input  var rat_snapshot_pkg::wb_tags_t   wb_tag_i,
    // checkpoint save and restore
    input  var logic                         restore_valid_i,
    input  var rat_snapshot_pkg::snap_tags_t restore_tags_i,
    input  var rat_snapshot_pkg::arch_vec_t  restore_ready_i,
    output var rat_snapshot_pkg::snap_tags_t snap_tags_o,
    output var rat_snapshot_pkg::arch_vec_t  snap_ready_o
);

    import rat_snapshot_pkg::*;

    // table state as it stands this cycle
    snap_tags_t cur_tags;
    arch_vec_t  cur_ready;

    // writeback matches against table and restore snapshot
    arch_vec_t  table_hit;
    arch_vec_t  snap_hit;

    // ========================================================================
    // input side: writeback tag compare
    // ========================================================================

    rat_wb_match u_wb_match (
        .wb_valid_i     (wb_valid_i),
        .wb_tag_i       (wb_tag_i),
        .cur_tags_i     (cur_tags),
        .restore_tags_i (restore_tags_i),
        .table_hit_o    (table_hit),
        .snap_hit_o     (snap_hit)
    );

    // ========================================================================
    // state: mapping registers and their next value
    // ========================================================================

    rat_table u_table (
        .clock           (clock),
        .reset           (reset),
        .ren_valid_i     (ren_valid_i),
        .ren_arch_i      (ren_arch_i),
        .ren_tag_i       (ren_tag_i),
        .table_hit_i     (table_hit),
        .snap_hit_i      (snap_hit),
        .restore_valid_i (restore_valid_i),
        .restore_tags_i  (restore_tags_i),
        .restore_ready_i (restore_ready_i),
        .cur_tags_o      (cur_tags),
        .cur_ready_o     (cur_ready),
        .snap_tags_o     (snap_tags_o),
        .snap_ready_o    (snap_ready_o)
    );

    // output side: operand and old-tag reads
    rat_lookup u_lookup (
        .rs1_arch_i      (rs1_arch_i),
        .rs2_arch_i      (rs2_arch_i),
        .ren_arch_i      (ren_arch_i),
        .cur_tags_i      (cur_tags),
        .cur_ready_i     (cur_ready),
        .table_hit_i     (table_hit),
        .restore_valid_i (restore_valid_i),
        .restore_tags_i  (restore_tags_i),
        .rs1_tag_o       (rs1_tag_o),
        .rs2_tag_o       (rs2_tag_o),
        .rs1_ready_o     (rs1_ready_o),
        .rs2_ready_o     (rs2_ready_o),
        .ren_old_tag_o   (ren_old_tag_o)
    );

endmodule

`default_nettype wire

/* verification/rat_tb_sva.sv */
// bound into rat_top, watches the registered table only
// expects the table to be the identity mapping one edge after reset

`timescale 1ns/1ps
`default_nettype none

module rat_tb_sva (
    input var logic                         clock,
    input var logic                         reset,
    input var rat_snapshot_pkg::snap_tags_t cur_tags_i,
    input var rat_snapshot_pkg::arch_vec_t  cur_ready_i
);

    import rat_config_pkg::*;
    import rat_snapshot_pkg::*;

    // entry i holds tag i
    function automatic snap_tags_t identity_tags();
        snap_tags_t tags;
        tags = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            tags[i*SNAP_SLICE_W +: SNAP_SLICE_W] = phys_tag_t'(i);
        end
        return tags;
    endfunction

    // table after any reset edge, all entries ready
    reset_identity: assert property (@(posedge clock)
        reset |=> (cur_tags_i == identity_tags()) && (cur_ready_i == '1))
        else $error("table is not the identity mapping after reset");

    // zero register is never renamed
    zero_reg_tag: assert property (@(posedge clock) disable iff (reset)
        cur_tags_i[int'(ZERO_REG)*SNAP_SLICE_W +: SNAP_SLICE_W] == phys_tag_t'(0))
        else $error("zero register does not hold tag 0");

    zero_reg_ready: assert property (@(posedge clock) disable iff (reset)
        cur_ready_i[ZERO_REG])
        else $error("zero register is not ready");

endmodule

`default_nettype wire

/* verification/rat_tb.sv */
// testbench for rat_top, inputs change 1 ns after the rising edge
// outputs are checked mid-cycle against a reference model of the table
// first wrong value ends the run, a watchdog bounds the run time

`timescale 1ns/1ps
`default_nettype none

module rat_tb;

    import rat_config_pkg::*;
    import rat_snapshot_pkg::*;

    localparam int CLOCK_PERIOD    = 8;
    localparam int RESET_CYCLES    = 3;
    // upper bound of the directed part
    localparam int DIRECTED_CYCLES = 64;
    localparam int RANDOM_CYCLES   = 400;
    localparam int WATCHDOG_NS     =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 50) * CLOCK_PERIOD;

    logic clock = 1'b0;
    logic reset;
    arch_idx_t rs1_arch, rs2_arch, ren_arch;
    phys_tag_t rs1_tag, rs2_tag, ren_tag, ren_old_tag;
    logic rs1_ready, rs2_ready, ren_valid, restore_valid;
    wb_vec_t wb_valid;
    phys_tag_t [WB_PORTS-1:0] wb_tag;
    phys_tag_t [ARCH_REGS-1:0] restore_tags;
    arch_vec_t restore_ready, snap_ready;
    snap_tags_t snap_tags;

    // ========================================================================
    // reference model
    // ========================================================================

    // table as it stands this cycle
    phys_tag_t [ARCH_REGS-1:0] m_tags;
    arch_vec_t m_ready;
    // table after this cycle's rename and writebacks
    phys_tag_t [ARCH_REGS-1:0] n_tags;
    arch_vec_t n_ready;
    // entries whose tag is written back this cycle
    arch_vec_t hit;
    // saved checkpoints for later restores
    phys_tag_t [ARCH_REGS-1:0] ckpt_tags [4];
    arch_vec_t ckpt_ready [4];
    string test_name;

    always #(CLOCK_PERIOD/2) clock = ~clock;

    rat_top UUT (
        .clock(clock), .reset(reset),
        .rs1_arch_i(rs1_arch), .rs2_arch_i(rs2_arch),
        .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag),
        .rs1_ready_o(rs1_ready), .rs2_ready_o(rs2_ready),
        .ren_valid_i(ren_valid), .ren_arch_i(ren_arch), .ren_tag_i(ren_tag),
        .ren_old_tag_o(ren_old_tag),
        .wb_valid_i(wb_valid), .wb_tag_i(wb_tag),
        .restore_valid_i(restore_valid), .restore_tags_i(restore_tags),
        .restore_ready_i(restore_ready),
        .snap_tags_o(snap_tags), .snap_ready_o(snap_ready)
    );

    bind rat_top rat_tb_sva u_sva (
        .clock(clock), .reset(reset), .cur_tags_i(cur_tags), .cur_ready_i(cur_ready)
    );

    // true if a valid writeback port carries this tag
    function automatic logic written_back(input phys_tag_t tag);
        logic found;
        found = 1'b0;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_valid[p] && (wb_tag[p] == tag)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_value(input string what, input snap_tags_t expected,
                               input snap_tags_t actual);
        assert (actual == expected) else begin
            $display("Mismatch in %s on %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "output check failed");
        end
    endtask

    // expected outputs for the inputs now applied
    task automatic check_outputs();
        phys_tag_t old_tag;
        for (int i = 0; i < ARCH_REGS; i++) begin
            hit[i] = written_back(m_tags[i]);
        end
        n_tags  = m_tags;
        n_ready = m_ready | hit;
        if (ren_valid && (ren_arch != ZERO_REG)) begin
            n_tags[ren_arch]  = ren_tag;
            n_ready[ren_arch] = 1'b0;
        end
        old_tag = restore_valid ? restore_tags[ren_arch] : m_tags[ren_arch];
        check_value("rs1_tag", snap_tags_t'(m_tags[rs1_arch]), snap_tags_t'(rs1_tag));
        check_value("rs2_tag", snap_tags_t'(m_tags[rs2_arch]), snap_tags_t'(rs2_tag));
        check_value("rs1_ready", snap_tags_t'(m_ready[rs1_arch] | hit[rs1_arch]),
                    snap_tags_t'(rs1_ready));
        check_value("rs2_ready", snap_tags_t'(m_ready[rs2_arch] | hit[rs2_arch]),
                    snap_tags_t'(rs2_ready));
        check_value("ren_old_tag", snap_tags_t'(old_tag), snap_tags_t'(ren_old_tag));
        check_value("snap_tags", snap_tags_t'(n_tags), snap_tags);
        check_value("snap_ready", snap_tags_t'(n_ready), snap_tags_t'(snap_ready));
    endtask

    // table state after the coming edge
    task automatic update_model();
        arch_vec_t merged;
        if (restore_valid) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                merged[i] = restore_ready[i]
                          | ((restore_tags[i] == m_tags[i]) && m_ready[i])
                          | written_back(restore_tags[i]);
            end
            m_tags  = restore_tags;
            m_ready = merged;
        end else begin
            m_tags  = n_tags;
            m_ready = n_ready;
        end
    endtask

    // check mid-cycle, then move to 1 ns after the next edge
    task automatic run_cycle();
        #4;
        check_outputs();
        update_model();
        @(posedge clock);
        #1;
    endtask

    task automatic clear_controls();
        ren_valid     = 1'b0;
        wb_valid      = '0;
        restore_valid = 1'b0;
    endtask

    task automatic save_checkpoint(input int slot);
        ckpt_tags[slot]  = n_tags;
        ckpt_ready[slot] = n_ready;
    endtask

    task automatic apply_restore(input int slot, input arch_vec_t ready_mask);
        restore_valid = 1'b1;
        restore_tags  = ckpt_tags[slot];
        restore_ready = ckpt_ready[slot] & ready_mask;
    endtask

    // ========================================================================
    // random traffic
    // ========================================================================

    task automatic random_cycles(input int count);
        int slot;
        for (int c = 0; c < count; c++) begin
            rs1_arch  = arch_idx_t'($urandom_range(ARCH_REGS-1, 0));
            rs2_arch  = arch_idx_t'($urandom_range(ARCH_REGS-1, 0));
            ren_valid = ($urandom_range(3, 0) != 0);
            ren_arch  = arch_idx_t'($urandom_range(ARCH_REGS-1, 0));
            ren_tag   = phys_tag_t'($urandom_range(PHYS_REGS-1, 0));
            wb_valid  = wb_vec_t'($urandom_range(3, 0));
            for (int p = 0; p < WB_PORTS; p++) begin
                wb_tag[p] = phys_tag_t'($urandom_range(PHYS_REGS-1, 0));
            end
            restore_valid = 1'b0;
            // occasional restore of an older checkpoint
            if ($urandom_range(15, 0) == 0) begin
                slot = $urandom_range(3, 0);
                apply_restore(slot, arch_vec_t'($urandom()));
            end
            run_cycle();
            if ($urandom_range(7, 0) == 0) begin
                slot = $urandom_range(3, 0);
                save_checkpoint(slot);
            end
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(63404));
        reset = 1'b1;
        rs1_arch = '0;
        rs2_arch = '0;
        ren_arch = '0;
        ren_tag = '0;
        wb_tag = '0;
        restore_tags = '0;
        restore_ready = '0;
        clear_controls();
        test_name = "reset";
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_tags[i] = phys_tag_t'(i);
        end
        m_ready = '1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        // identity lookups of every register
        test_name = "reset_identity";
        for (int r = 0; r < ARCH_REGS; r++) begin
            rs1_arch = arch_idx_t'(r);
            rs2_arch = arch_idx_t'(ARCH_REGS - 1 - r);
            run_cycle();
        end
        for (int s = 0; s < 4; s++) begin
            save_checkpoint(s);
        end

        // two registers share tag 20, zero register rename is dropped
        test_name = "rename";
        ren_valid = 1'b1;
        ren_arch = 4'd3;
        ren_tag = 5'd20;
        rs1_arch = 4'd3;
        run_cycle();
        ren_arch = 4'd7;
        run_cycle();
        ren_arch = ZERO_REG;
        ren_tag = 5'd25;
        rs1_arch = ZERO_REG;
        rs2_arch = 4'd7;
        run_cycle();
        clear_controls();
        run_cycle();

        // forward tag 20, and rename 5 while its old tag 5 comes back
        test_name = "writeback";
        wb_valid = 2'b11;
        wb_tag[0] = 5'd20;
        wb_tag[1] = 5'd5;
        ren_valid = 1'b1;
        ren_arch = 4'd5;
        ren_tag = 5'd21;
        rs1_arch = 4'd3;
        rs2_arch = 4'd5;
        run_cycle();
        clear_controls();
        run_cycle();

        // save, rename over it, restore with tag 22 landing in that cycle
        test_name = "snapshot_restore";
        ren_valid = 1'b1;
        ren_arch = 4'd9;
        ren_tag = 5'd22;
        run_cycle();
        save_checkpoint(0);
        ren_tag = 5'd23;
        run_cycle();
        ren_arch = 4'd12;
        ren_tag = 5'd24;
        run_cycle();
        clear_controls();
        apply_restore(0, '1);
        wb_valid = 2'b01;
        wb_tag[0] = 5'd22;
        rs1_arch = 4'd9;
        rs2_arch = 4'd12;
        run_cycle();
        clear_controls();
        run_cycle();

        // rename in a restore cycle is ignored
        test_name = "restore_with_rename";
        ren_valid = 1'b1;
        ren_arch = 4'd12;
        ren_tag = 5'd30;
        run_cycle();
        apply_restore(0, 16'h00ff);
        run_cycle();
        clear_controls();
        run_cycle();

        test_name = "random";
        random_cycles(RANDOM_CYCLES);
        clear_controls();
        run_cycle();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/rat_config_pkg.sv
hw/rat_snapshot_pkg.sv
hw/rat_wb_match.sv
hw/rat_table.sv
hw/rat_lookup.sv
hw/rat_top.sv
verification/rat_tb_sva.sv
verification/rat_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the alias table regression with Verilator and run it
# the exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rat_tb -Mdir obj_dir -f build.f

./obj_dir/Vrat_tb
